// File: Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert
TOP   ?= fetch_tb
FLIST ?= fetch.f

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  fetch_pkg::pc_t lookup_pc_i,
    output logic           hit_o,
    output logic           taken_o,
    output fetch_pkg::pc_t target_o,
    output logic           slot_o,
    input  logic           upd_valid_i,
    input  fetch_pkg::pc_t upd_pc_i,
    input  fetch_pkg::pc_t upd_target_i,
    input  logic           upd_taken_i,
    input  logic           upd_rvc_i
);
    import fetch_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_ENTRIES-1:0] slot_q;
    logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
    pc_t                    target_q [BTB_ENTRIES];
    logic [1:0]             ctr_q [BTB_ENTRIES];
    logic [BTB_IDX_W-1:0]   rd_idx;
    logic [BTB_IDX_W-1:0]   wr_idx;
    logic [BTB_TAG_W-1:0]   wr_tag;
    logic                   upd_hit;
    logic                   upd_skip;
    logic                   upd_en;
    logic [1:0]             ctr_nxt;

    // lookup by word address, purely combinational
    assign rd_idx   = lookup_pc_i[BTB_IDX_W+1:2];
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc_i[PC_W-1:BTB_IDX_W+2]);
    // msb of the counter, weakly or strongly taken
    assign taken_o  = ctr_q[rd_idx][1];
    assign target_o = target_q[rd_idx];
    assign slot_o   = slot_q[rd_idx];

    assign wr_idx = upd_pc_i[BTB_IDX_W+1:2];
    assign wr_tag = upd_pc_i[PC_W-1:BTB_IDX_W+2];
    // hit needs the same branch, so the slot has to match too
    assign upd_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag) &&
                     (slot_q[wr_idx] == upd_pc_i[1]);
    // 32-bit branch in the upper half crosses the word, never predicted
    assign upd_skip = !upd_rvc_i && upd_pc_i[1];
    // misses only allocate when taken
    assign upd_en = upd_valid_i && !upd_skip && (upd_hit || upd_taken_i);

    // saturating 2-bit counter, fresh entries start weakly taken
    always_comb begin
        ctr_nxt = ctr_q[wr_idx];
        if (!upd_hit) begin
            ctr_nxt = 2'd2;
        end else if (upd_taken_i && ctr_q[wr_idx] != 2'd3) begin
            ctr_nxt = ctr_q[wr_idx] + 2'd1;
        end else if (!upd_taken_i && ctr_q[wr_idx] != 2'd0) begin
            ctr_nxt = ctr_q[wr_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            tag_q[wr_idx]  <= wr_tag;
            slot_q[wr_idx] <= upd_pc_i[1];
            ctr_q[wr_idx]  <= ctr_nxt;
            if (upd_taken_i) begin
                target_q[wr_idx] <= upd_target_i;
            end
        end
    end

endmodule

// File: fetch.f
fetch_pkg.sv
fetch_meta_if.sv
fetch_fifo.sv
branch_predictor.sv
fetch_pc_gen.sv
fetch_align.sv
fetch_top.sv
fetch_tb.sv

// File: fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  fetch_pkg::instr_t mem_rsp_data_i,
    input  logic              mem_rsp_valid_i,
    fetch_meta_if.align       meta,
    output fetch_pkg::instr_t dec_instr_o,
    output fetch_pkg::pc_t    dec_pc_o,
    output logic              dec_rvc_o,
    output logic              dec_taken_o,
    output logic              dec_valid_o,
    input  logic              dec_credit_i
);
    import fetch_pkg::*;

    fetch_meta_t          head_meta;
    instr_t               head_word;
    logic                 meta_empty;
    logic                 data_empty;
    logic                 epoch_q;
    logic                 off_q;
    logic                 off_d;
    logic                 carry_v_q;
    logic                 carry_v_d;
    logic                 carry_ld;
    logic [15:0]          carry_lo_q;
    pc_t                  carry_pc_q;
    logic [RSP_CNT_W-1:0] pend_q;
    logic [RSP_CNT_W-1:0] pend_d;
    logic [RSP_CNT_W-1:0] stale_q;
    logic [RSP_CNT_W-1:0] stale_d;
    logic [DEC_CNT_W-1:0] dcred_q;
    logic                 hw_pos;
    logic [15:0]          hw_lo;
    logic [15:0]          hw_hi;
    logic                 drop;
    logic                 has_cred;
    logic                 pop;
    logic                 emit;
    instr_t               instr_d;
    pc_t                  pc_d;
    logic                 rvc_d;
    logic                 taken_d;

    // sideband pushed on request accept, so it always leads its data
    fetch_fifo #(.DEPTH(RSP_DEPTH), .T(fetch_meta_t)) u_meta_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (meta.meta_valid),
        .data_i  (meta.meta),
        .pop_i   (pop),
        .flush_i (1'b0),
        .data_o  (head_meta),
        .empty_o (meta_empty),
        .full_o  ()
    );

    fetch_fifo #(.DEPTH(RSP_DEPTH), .T(instr_t)) u_data_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (mem_rsp_valid_i),
        .data_i  (mem_rsp_data_i),
        .pop_i   (pop),
        .flush_i (1'b0),
        .data_o  (head_word),
        .empty_o (data_empty),
        .full_o  ()
    );

    // lower half already used, or never part of the stream
    assign hw_pos   = off_q | head_meta.start_hi;
    assign hw_lo    = head_word[15:0];
    assign hw_hi    = head_word[31:16];
    // one-bit epoch aliases after two redirects, stale count covers that case
    assign drop     = (head_meta.epoch != epoch_q) || (stale_q != '0);
    assign has_cred = (dcred_q != '0);

    always_comb begin
        pop       = 1'b0;
        emit      = 1'b0;
        carry_ld  = 1'b0;
        off_d     = off_q;
        carry_v_d = carry_v_q;
        instr_d   = dec_instr_o;
        pc_d      = dec_pc_o;
        rvc_d     = dec_rvc_o;
        taken_d   = dec_taken_o;
        if (!meta.flush && !data_empty && !meta_empty) begin
            if (drop) begin
                // old path, give the slot back silently
                pop   = 1'b1;
                off_d = 1'b0;
            end else if (carry_v_q) begin
                // finish the instruction split across words
                emit      = has_cred;
                instr_d   = {hw_lo, carry_lo_q};
                pc_d      = carry_pc_q;
                rvc_d     = 1'b0;
                taken_d   = 1'b0;
                carry_v_d = !has_cred;
                off_d     = has_cred;
            end else if (!hw_pos) begin
                emit    = has_cred;
                pc_d    = head_meta.word_pc;
                taken_d = head_meta.pred_taken && !head_meta.pred_slot;
                if (hw_lo[1:0] != 2'b11) begin
                    instr_d = {16'h0000, hw_lo};
                    rvc_d   = 1'b1;
                    // taken branch ends the word
                    pop     = has_cred && taken_d;
                    off_d   = has_cred ? !taken_d : off_q;
                end else begin
                    instr_d = head_word;
                    rvc_d   = 1'b0;
                    pop     = has_cred;
                end
            end else if (hw_hi[1:0] != 2'b11) begin
                emit    = has_cred;
                instr_d = {16'h0000, hw_hi};
                pc_d    = head_meta.word_pc + pc_t'(2);
                rvc_d   = 1'b1;
                taken_d = head_meta.pred_taken && head_meta.pred_slot;
                pop     = has_cred;
                off_d   = has_cred ? 1'b0 : off_q;
            end else begin
                // upper half opens a 32-bit instr, park it
                pop       = 1'b1;
                carry_ld  = 1'b1;
                carry_v_d = 1'b1;
                off_d     = 1'b0;
            end
        end
        if (meta.flush) begin
            off_d     = 1'b0;
            carry_v_d = 1'b0;
        end
    end

    // pairs queued or in flight, all of them stale on a flush
    assign pend_d  = pend_q + RSP_CNT_W'(meta.meta_valid) - RSP_CNT_W'(pop);
    assign stale_d = meta.flush ? pend_d : stale_q - RSP_CNT_W'(pop && stale_q != '0);

    assign meta.credit = pop;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            epoch_q     <= 1'b0;
            off_q       <= 1'b0;
            carry_v_q   <= 1'b0;
            pend_q      <= '0;
            stale_q     <= '0;
            dcred_q     <= DEC_CNT_W'(DEC_CREDITS);
            dec_valid_o <= 1'b0;
        end else begin
            epoch_q     <= epoch_q ^ meta.flush;
            off_q       <= off_d;
            carry_v_q   <= carry_v_d;
            pend_q      <= pend_d;
            stale_q     <= stale_d;
            dcred_q     <= dcred_q - DEC_CNT_W'(emit) + DEC_CNT_W'(dec_credit_i);
            dec_valid_o <= emit;
        end
    end

    // payload, held while the decoder is out of credits
    always_ff @(posedge clk_i) begin
        if (emit) begin
            dec_instr_o <= instr_d;
            dec_pc_o    <= pc_d;
            dec_rvc_o   <= rvc_d;
            dec_taken_o <= taken_d;
        end
        if (carry_ld) begin
            carry_lo_q <= hw_hi;
            carry_pc_q <= head_meta.word_pc + pc_t'(2);
        end
    end

    // decoder handing back more than it was given would allow an uncredited send
    a_dec_credit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dcred_q <= DEC_CNT_W'(DEC_CREDITS))
        else $error("fetch_align: decode credit overflow");

endmodule

// File: fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [31:0]
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    input  logic flush_i,
    output T     data_o,
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;

    // pointers, occupancy
    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // showahead, head entry always on the output
    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == CNT_W'(DEPTH));

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i) !(push_i && full_o))
        else $error("fetch_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn_i) !(pop_i && empty_o))
        else $error("fetch_fifo: pop while empty");

endmodule

// File: fetch_meta_if.sv
`timescale 1ns/1ps

interface fetch_meta_if;
    import fetch_pkg::*;

    // request sideband, valid for one cycle per accepted read
    fetch_meta_t meta;
    logic        meta_valid;
    // same cycle as the redirect from execute
    logic        flush;
    // one pulse per response pair leaving the buffer
    logic        credit;

    modport gen (output meta, output meta_valid, output flush, input credit);

    modport align (input meta, input meta_valid, input flush, output credit);

endinterface

// File: fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  fetch_pkg::pc_t redirect_pc_i,
    input  logic           redirect_valid_i,
    input  logic           upd_valid_i,
    input  fetch_pkg::pc_t upd_pc_i,
    input  fetch_pkg::pc_t upd_target_i,
    input  logic           upd_taken_i,
    input  logic           upd_rvc_i,
    output fetch_pkg::pc_t mem_req_addr_o,
    output logic           mem_req_valid_o,
    input  logic           mem_req_ready_i,
    fetch_meta_if.gen      meta
);
    import fetch_pkg::*;

    pc_t                  pc_q;
    pc_t                  word_pc;
    pc_t                  next_pc;
    logic                 epoch_q;
    logic                 run_q;
    logic [RSP_CNT_W-1:0] credit_q;
    logic                 accept;
    logic                 bp_hit;
    logic                 bp_taken;
    pc_t                  bp_target;
    logic                 bp_slot;
    logic                 pred_taken;

    branch_predictor u_bp (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .lookup_pc_i  (pc_q),
        .hit_o        (bp_hit),
        .taken_o      (bp_taken),
        .target_o     (bp_target),
        .slot_o       (bp_slot),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_target_i (upd_target_i),
        .upd_taken_i  (upd_taken_i),
        .upd_rvc_i    (upd_rvc_i)
    );

    assign word_pc = {pc_q[PC_W-1:2], 2'b00};
    // branch in the low slot is behind us when the fetch starts high
    assign pred_taken = bp_hit && bp_taken && (bp_slot || !pc_q[1]);
    assign next_pc    = pred_taken ? bp_target : word_pc + pc_t'(4);

    // only issue with a free response slot
    assign mem_req_valid_o = run_q && (credit_q != '0);
    assign mem_req_addr_o  = word_pc;
    assign accept          = mem_req_valid_o && mem_req_ready_i;

    assign meta.meta = '{
        word_pc:    word_pc,
        start_hi:   pc_q[1],
        pred_taken: pred_taken,
        pred_slot:  bp_slot,
        epoch:      epoch_q
    };
    assign meta.meta_valid = accept;
    assign meta.flush      = redirect_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_q     <= RESET_PC;
            epoch_q  <= 1'b0;
            run_q    <= 1'b0;
            credit_q <= RSP_CNT_W'(RSP_DEPTH);
        end else begin
            run_q    <= 1'b1;
            // request accepted this cycle still holds its slot after a redirect
            credit_q <= credit_q - RSP_CNT_W'(accept) + RSP_CNT_W'(meta.credit);
            if (redirect_valid_i) begin
                pc_q    <= redirect_pc_i;
                epoch_q <= ~epoch_q;
            end else if (accept) begin
                pc_q <= next_pc;
            end
        end
    end

    // align must never hand back more slots than exist
    a_credit_max: assert property (@(posedge clk_i) disable iff (!rstn_i)
        credit_q <= RSP_CNT_W'(RSP_DEPTH))
        else $error("fetch_pc_gen: response credit overflow");

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

    // address and word widths
    localparam int PC_W    = 32;
    localparam int INSTR_W = 32;

    // byte address
    typedef logic [PC_W-1:0] pc_t;
    // instruction or raw memory word
    typedef logic [INSTR_W-1:0] instr_t;

    // first fetch address out of reset
    localparam pc_t RESET_PC = 32'h0000_0100;

    // response buffer slots, also max reads in flight
    localparam int RSP_DEPTH   = 4;
    // instructions the decoder can absorb before a credit comes back
    localparam int DEC_CREDITS = 4;

    // btb geometry, index taken from word address bits above the byte offset
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = PC_W - BTB_IDX_W - 2;

    // counter widths, sized to hold the full count
    localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);
    localparam int DEC_CNT_W = $clog2(DEC_CREDITS + 1);

    // per-request sideband, travels next to each memory read
    typedef struct packed {
        // word-aligned read address
        pc_t  word_pc;
        // lower halfword is not part of the stream
        logic start_hi;
        logic pred_taken;
        // halfword where the predicted branch begins
        logic pred_slot;
        logic epoch;
    } fetch_meta_t;

endpackage

// File: fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    // instructions checked per test
    localparam int N_SEQ    = 60;
    localparam int N_ODD    = 40;
    localparam int N_HOLD   = 30;
    localparam int N_STALL  = 40;
    localparam int N_BRANCH = 50;
    localparam int TOTAL    = N_SEQ + N_ODD + N_HOLD + N_STALL + N_BRANCH;
    localparam int HOLD_CYC = 60;
    // image spans byte addresses 0x000 to 0x7ff
    localparam int IMG_HW   = 1024;
    localparam int WALK_LEN = 260;

    logic   clk_i;
    logic   rstn_i;
    pc_t    mem_req_addr_o;
    logic   mem_req_valid_o;
    logic   mem_req_ready_i;
    instr_t mem_rsp_data_i;
    logic   mem_rsp_valid_i;
    instr_t dec_instr_o;
    pc_t    dec_pc_o;
    logic   dec_rvc_o;
    logic   dec_taken_o;
    logic   dec_valid_o;
    logic   dec_credit_i;
    pc_t    redirect_pc_i;
    logic   redirect_valid_i;
    logic   upd_valid_i;
    pc_t    upd_pc_i;
    pc_t    upd_target_i;
    logic   upd_taken_i;
    logic   upd_rvc_i;

    logic [15:0]            img [IMG_HW];
    logic [31:0]            lfsr_q;
    // expected target buffer state
    logic [BTB_ENTRIES-1:0] m_valid;
    logic [BTB_ENTRIES-1:0] m_slot;
    logic [BTB_TAG_W-1:0]   m_tag [BTB_ENTRIES];
    pc_t                    m_target [BTB_ENTRIES];
    logic [1:0]             m_ctr [BTB_ENTRIES];
    // instruction starts of the sequential walk from reset
    pc_t                    bnd [WALK_LEN];
    pc_t                    exp_pc;
    int                     n_checked;
    int                     n_taken;
    int                     owed;
    int                     cycle;
    logic                   hold;
    logic                   heavy;
    // reads in flight, oldest first
    pc_t                    rsp_addr_q [$];
    int                     rsp_due_q [$];

    fetch_top dut0 (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_data_i   (mem_rsp_data_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .dec_instr_o      (dec_instr_o),
        .dec_pc_o         (dec_pc_o),
        .dec_rvc_o        (dec_rvc_o),
        .dec_taken_o      (dec_taken_o),
        .dec_valid_o      (dec_valid_o),
        .dec_credit_i     (dec_credit_i),
        .redirect_pc_i    (redirect_pc_i),
        .redirect_valid_i (redirect_valid_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_target_i     (upd_target_i),
        .upd_taken_i      (upd_taken_i),
        .upd_rvc_i        (upd_rvc_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // right-shift galois step
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    // outside the image, fold the full address
    function automatic logic [15:0] img_hw(input pc_t addr);
        if (addr < pc_t'(2 * IMG_HW)) begin
            return img[addr[10:1]];
        end else begin
            return addr[31:16] ^ addr[15:0];
        end
    endfunction

    // mixed stream from the reset address upward
    task automatic build_image();
        int         i;
        logic [1:0] op;
        for (i = 0; i < 'h80; i++) begin
            img[i] = 16'(rand_bits(16));
        end
        i = 'h80;
        while (i < IMG_HW) begin
            if (rand_bits(1) == 32'd1 || i == IMG_HW - 1) begin
                op = 2'(rand_bits(2));
                // 11 would mean a 32-bit opcode
                if (op == 2'b11) begin
                    op = 2'b01;
                end
                img[i] = {14'(rand_bits(14)), op};
                i      = i + 1;
            end else begin
                img[i]     = {14'(rand_bits(14)), 2'b11};
                img[i + 1] = 16'(rand_bits(16));
                i          = i + 2;
            end
        end
    endtask

    // length rule plus predicted redirect
    function automatic void ref_instr(input pc_t pc, output instr_t instr, output logic rvc,
                                      output logic taken, output pc_t next_pc);
        logic [15:0]          lo;
        logic [BTB_IDX_W-1:0] idx;
        lo    = img_hw(pc);
        idx   = pc[BTB_IDX_W+1:2];
        rvc   = (lo[1:0] != 2'b11);
        instr = rvc ? {16'h0000, lo} : {img_hw(pc + pc_t'(2)), lo};
        taken = m_valid[idx] && (m_tag[idx] == pc[PC_W-1:BTB_IDX_W+2]) &&
                (m_slot[idx] == pc[1]) && (m_ctr[idx] >= 2'd2);
        next_pc = taken ? m_target[idx] : pc + (rvc ? pc_t'(2) : pc_t'(4));
    endfunction

    function automatic void update_model(input pc_t pc, input pc_t tgt, input logic taken,
                                         input logic rvc);
        logic [BTB_IDX_W-1:0] idx;
        logic                 hit;
        idx = pc[BTB_IDX_W+1:2];
        hit = m_valid[idx] && (m_tag[idx] == pc[PC_W-1:BTB_IDX_W+2]) && (m_slot[idx] == pc[1]);
        // 32-bit branch in the upper half crosses the word
        if (rvc || !pc[1]) begin
            if (!hit && taken) begin
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = pc[PC_W-1:BTB_IDX_W+2];
                m_slot[idx]   = pc[1];
                m_target[idx] = tgt;
                m_ctr[idx]    = 2'd2;
            end else if (hit && taken) begin
                m_target[idx] = tgt;
                m_ctr[idx]    = (m_ctr[idx] == 2'd3) ? 2'd3 : m_ctr[idx] + 2'd1;
            end else if (hit) begin
                m_ctr[idx] = (m_ctr[idx] == 2'd0) ? 2'd0 : m_ctr[idx] - 2'd1;
            end
        end
    endfunction

    task automatic wait_for_instr(input int n);
        int target;
        target = n_checked + n;
        while (n_checked < target) begin
            @(posedge clk_i);
        end
    endtask

    task automatic redirect_to(input pc_t pc, input logic train, input pc_t br_pc,
                               input pc_t br_tgt);
        logic [15:0] hw;
        hw = img_hw(br_pc);
        @(negedge clk_i);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        upd_valid_i      = train;
        upd_pc_i         = br_pc;
        upd_target_i     = br_tgt;
        upd_taken_i      = 1'b1;
        upd_rvc_i        = (hw[1:0] != 2'b11);
        @(negedge clk_i);
        redirect_valid_i = 1'b0;
        upd_valid_i      = 1'b0;
    endtask

    // memory and decoder models, all randomness after reset comes from here
    initial begin
        pc_t a;
        int  lat;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        dec_credit_i    = 1'b0;
        owed            = 0;
        cycle           = 0;
        forever begin
            @(negedge clk_i);
            cycle++;
            // in-order responses once due
            if (rsp_addr_q.size() != 0 && rsp_due_q[0] <= cycle) begin
                a               = rsp_addr_q.pop_front();
                lat             = rsp_due_q.pop_front();
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = {img_hw(a + pc_t'(2)), img_hw(a)};
            end else begin
                mem_rsp_valid_i = 1'b0;
            end
            mem_req_ready_i = heavy ? (rand_bits(2) == 32'd0) : (rand_bits(2) != 32'd0);
            // accepted at the coming edge, answered one cycle later at the earliest
            if (mem_req_valid_o === 1'b1 && mem_req_ready_i) begin
                lat = heavy ? int'(rand_bits(4)) : int'(rand_bits(2));
                rsp_addr_q.push_back(mem_req_addr_o);
                rsp_due_q.push_back(cycle + 1 + lat);
            end
            if (dec_valid_o === 1'b1) begin
                owed++;
            end
            if (owed > DEC_CREDITS) begin
                report_failure("decoder received more instructions than it had credits for");
            end
            if (owed != 0 && !hold && rand_bits(1) == 32'd1) begin
                dec_credit_i = 1'b1;
                owed--;
            end else begin
                dec_credit_i = 1'b0;
            end
        end
    end

    // outputs checked on the falling edge, redirects and updates taken on the rising one
    initial begin
        instr_t e_instr;
        logic   e_rvc;
        logic   e_taken;
        pc_t    e_next;
        exp_pc    = RESET_PC;
        n_checked = 0;
        n_taken   = 0;
        forever begin
            @(negedge clk_i);
            if (dec_valid_o === 1'b1) begin
                ref_instr(exp_pc, e_instr, e_rvc, e_taken, e_next);
                check_pc("dec_pc_o", dec_pc_o, exp_pc);
                check_instr("dec_instr_o", dec_instr_o, e_instr);
                check_flag("dec_rvc_o", dec_rvc_o, e_rvc);
                check_flag("dec_taken_o", dec_taken_o, e_taken);
                exp_pc = e_next;
                n_checked++;
                if (e_taken) begin
                    n_taken++;
                end
            end
            @(posedge clk_i);
            if (redirect_valid_i === 1'b1) begin
                exp_pc = redirect_pc_i;
            end
            if (upd_valid_i === 1'b1) begin
                update_model(upd_pc_i, upd_target_i, upd_taken_i, upd_rvc_i);
            end
        end
    end

    initial begin
        repeat (TOTAL * 200 + HOLD_CYC + 16) @(posedge clk_i);
        report_failure("timeout: decode stream stopped before all tests finished");
    end

    initial begin
        pc_t         s2;
        pc_t         s5;
        pc_t         br_pc;
        logic [15:0] hw;
        instr_t      t_instr;
        logic        t_rvc;
        logic        t_taken;
        int          k;
        int          base_taken;
        rstn_i           = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        upd_valid_i      = 1'b0;
        upd_pc_i         = '0;
        upd_target_i     = '0;
        upd_taken_i      = 1'b0;
        upd_rvc_i        = 1'b0;
        hold             = 1'b0;
        heavy            = 1'b0;
        m_valid          = '0;
        m_slot           = '0;
        lfsr_q           = 32'h1541;
        build_image();
        // empty predictor, so this is the plain sequential path
        bnd[0] = RESET_PC;
        for (k = 1; k < WALK_LEN; k++) begin
            ref_instr(bnd[k-1], t_instr, t_rvc, t_taken, bnd[k]);
        end
        s2 = '0;
        for (k = 120; k < WALK_LEN; k++) begin
            if (s2 == '0 && bnd[k][1]) begin
                s2 = bnd[k];
            end
        end
        s5    = bnd[200];
        br_pc = '0;
        // branch must fit in one word
        for (k = 212; k < WALK_LEN; k++) begin
            hw = img_hw(bnd[k]);
            if (br_pc == '0 && (hw[1:0] != 2'b11 || !bnd[k][1])) begin
                br_pc = bnd[k];
            end
        end
        if (s2 == '0 || br_pc == '0) begin
            report_failure("program image has no usable redirect or branch address");
        end

        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;

        // sequential mixed stream from reset
        wait_for_instr(N_SEQ);

        // redirect into an upper halfword
        redirect_to(s2, 1'b0, '0, '0);
        wait_for_instr(N_ODD);

        // decoder stops returning credits
        @(posedge clk_i);
        hold = 1'b1;
        repeat (HOLD_CYC) @(posedge clk_i);
        if (owed != DEC_CREDITS) begin
            report_failure("fetch did not use up its decode credits while they were withheld");
        end
        hold = 1'b0;
        wait_for_instr(N_HOLD);

        // long latency, frequent ready stalls
        @(posedge clk_i);
        heavy = 1'b1;
        wait_for_instr(N_STALL);
        heavy = 1'b0;

        // train a loop back to s5, counter ends strongly taken
        base_taken = n_taken;
        redirect_to(s5, 1'b1, br_pc, s5);
        redirect_to(s5, 1'b1, br_pc, s5);
        wait_for_instr(N_BRANCH);
        if (n_taken == base_taken) begin
            report_failure("no predicted-taken branch reached the decoder");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    output fetch_pkg::pc_t    mem_req_addr_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    input  fetch_pkg::instr_t mem_rsp_data_i,
    input  logic              mem_rsp_valid_i,
    output fetch_pkg::instr_t dec_instr_o,
    output fetch_pkg::pc_t    dec_pc_o,
    output logic              dec_rvc_o,
    output logic              dec_taken_o,
    output logic              dec_valid_o,
    input  logic              dec_credit_i,
    input  fetch_pkg::pc_t    redirect_pc_i,
    input  logic              redirect_valid_i,
    input  logic              upd_valid_i,
    input  fetch_pkg::pc_t    upd_pc_i,
    input  fetch_pkg::pc_t    upd_target_i,
    input  logic              upd_taken_i,
    input  logic              upd_rvc_i
);

    // sideband, flush and slot credits between the two stages
    fetch_meta_if meta_if ();

    fetch_pc_gen u_pc_gen (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_pc_i    (redirect_pc_i),
        .redirect_valid_i (redirect_valid_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_target_i     (upd_target_i),
        .upd_taken_i      (upd_taken_i),
        .upd_rvc_i        (upd_rvc_i),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .meta             (meta_if.gen)
    );

    fetch_align u_align (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .meta            (meta_if.align),
        .dec_instr_o     (dec_instr_o),
        .dec_pc_o        (dec_pc_o),
        .dec_rvc_o       (dec_rvc_o),
        .dec_taken_o     (dec_taken_o),
        .dec_valid_o     (dec_valid_o),
        .dec_credit_i    (dec_credit_i)
    );

endmodule
